// File: hw/cpuPkg.sv
// ----------------------------------------------------------
// Subset ISA only: ADDU SUBU AND OR SLT ADDIU LW SW BEQ
// Zero value of every stage payload is a bubble
// ----------------------------------------------------------
package cpuPkg;

    localparam int dataWidth    = 32;
    localparam int addrWidth    = 16;    // Instruction and data byte address
    localparam int regAddrWidth = 5;

    // Opcodes -----------------------------------------------
    localparam logic [5:0] opRType = 6'h00;
    localparam logic [5:0] opAddiu = 6'h09;
    localparam logic [5:0] opLw    = 6'h23;
    localparam logic [5:0] opSw    = 6'h2b;
    localparam logic [5:0] opBeq   = 6'h04;

    // R-type function field
    localparam logic [5:0] fnAddu = 6'h21;
    localparam logic [5:0] fnSubu = 6'h23;
    localparam logic [5:0] fnAnd  = 6'h24;
    localparam logic [5:0] fnOr   = 6'h25;
    localparam logic [5:0] fnSlt  = 6'h2a;

    typedef enum logic [2:0] {aluAdd, aluSub, aluAnd, aluOr, aluSlt} aluOpT;

    typedef enum logic [1:0] {none, fromMem, fromWb} fwdSelT;

    // Stage payloads ----------------------------------------
    typedef struct packed {
        logic  regWrite;
        logic  memRead;
        logic  memWrite;
        logic  memToReg;
        logic  aluSrc;     // Immediate as operand B
        logic  branch;
        aluOpT aluOp;
    } ctrlT;

    typedef struct packed {
        ctrlT                    ctrl;
        logic [addrWidth-1:0]    pc;
        logic [dataWidth-1:0]    rsData;
        logic [dataWidth-1:0]    rtData;
        logic [dataWidth-1:0]    immData;
        logic [regAddrWidth-1:0] rsAddr;
        logic [regAddrWidth-1:0] rtAddr;
        logic [regAddrWidth-1:0] destAddr;
    } idExT;

    typedef struct packed {
        ctrlT                    ctrl;
        logic [dataWidth-1:0]    aluResult;
        logic [dataWidth-1:0]    storeData;
        logic [regAddrWidth-1:0] destAddr;
    } exMemT;

    typedef struct packed {
        logic                    regWrite;
        logic                    memToReg;
        logic [dataWidth-1:0]    aluResult;   // Load data already merged in
        logic [regAddrWidth-1:0] destAddr;
    } memWbT;

endpackage

// File: hw/pipeReg.sv
// ----------------------------------------------------------
// One cycle stage register, flush wins over hold
// ----------------------------------------------------------
`timescale 1ns/1ps

module pipeReg #(
    parameter type Payload = logic
) (
    input  logic   Clock,
    input  logic   nReset,
    input  logic   hold,
    input  logic   flush,
    input  Payload d,
    output Payload q
);

    always_ff @(posedge Clock or negedge nReset)
    begin
        if (!nReset)
            q <= '0;
        else if (flush)
            q <= '0;               // Bubble
        else if (!hold)
            q <= d;
    end

    // Stall and branch squash never meet on the ID/EX register
    assert property (@(posedge Clock) disable iff (!nReset) !(hold && flush))
        else $error("pipeReg: hold and flush together");

endmodule

// File: hw/fetchStage.sv
// ----------------------------------------------------------
// Program counter, steps by 4, no delay slot
// ----------------------------------------------------------
`timescale 1ns/1ps

module fetchStage (
    input  logic                         Clock,
    input  logic                         nReset,
    input  logic                         nStall,
    input  logic                         branchTaken,
    input  logic [cpuPkg::addrWidth-1:0] branchTarget,
    output logic [cpuPkg::addrWidth-1:0] InstrAddr
);
    import cpuPkg::*;

    logic [addrWidth-1:0] pc;

    always_ff @(posedge Clock or negedge nReset)
    begin
        if (!nReset)
            pc <= '0;
        else if (branchTaken)                // Branch beats the stall
            pc <= branchTarget;
        else if (nStall)
            pc <= pc + addrWidth'(4);
    end

    assign InstrAddr = pc;

    // Branch offsets are word scaled, so pc never leaves word alignment
    assert property (@(posedge Clock) disable iff (!nReset) pc[1:0] == 2'b00)
        else $error("fetchStage: pc not word aligned");

endmodule

// File: hw/decodeStage.sv
// ----------------------------------------------------------
// IF/ID register, decode and 32 x 32 register file
// Register 0 reads 0, writeback passes through in same cycle
// ----------------------------------------------------------
`timescale 1ns/1ps

module decodeStage (
    input  logic                            Clock,
    input  logic                            nReset,
    input  logic [cpuPkg::dataWidth-1:0]    InstrMem,
    input  logic [cpuPkg::addrWidth-1:0]    pcIn,
    input  logic                            nStall,
    input  logic                            flush,
    input  logic                            wbRegWrite,
    input  logic [cpuPkg::regAddrWidth-1:0] wbAddr,
    input  logic [cpuPkg::dataWidth-1:0]    wbData,
    input  logic [cpuPkg::regAddrWidth-1:0] RegAddr,
    output logic [cpuPkg::dataWidth-1:0]    RegData,
    output logic [cpuPkg::regAddrWidth-1:0] rsAddr,
    output logic [cpuPkg::regAddrWidth-1:0] rtAddr,
    output cpuPkg::idExT                    idEx
);
    import cpuPkg::*;

    logic [dataWidth-1:0] instrQ;
    logic [addrWidth-1:0] pcQ;
    logic [dataWidth-1:0] regFile [32];
    ctrlT                 ctrl;
    logic [regAddrWidth-1:0] destAddr;

    function automatic logic [dataWidth-1:0] readReg(input logic [regAddrWidth-1:0] addr);
        if (addr == '0)
            return '0;
        else if (wbRegWrite && wbAddr == addr)
            return wbData;                    // Write-through
        else
            return regFile[addr];
    endfunction

    // IF/ID register ----------------------------------------
    always_ff @(posedge Clock or negedge nReset)
    begin
        if (!nReset)
        begin
            instrQ <= '0;
            pcQ    <= '0;
        end
        else if (flush)
        begin
            instrQ <= '0;                     // Word 0 decodes to a bubble
            pcQ    <= '0;
        end
        else if (nStall)
        begin
            instrQ <= InstrMem;
            pcQ    <= pcIn;
        end
    end

    always_ff @(posedge Clock)
        if (wbRegWrite && wbAddr != '0)
            regFile[wbAddr] <= wbData;

    assign rsAddr = instrQ[25:21];
    assign rtAddr = instrQ[20:16];

    // Control decode ----------------------------------------
    always_comb
    begin
        ctrl     = '0;
        destAddr = rtAddr;
        case (instrQ[31:26])
            opRType:
            begin
                destAddr      = instrQ[15:11];
                ctrl.regWrite = 1'b1;
                case (instrQ[5:0])
                    fnAddu:  ctrl.aluOp = aluAdd;
                    fnSubu:  ctrl.aluOp = aluSub;
                    fnAnd:   ctrl.aluOp = aluAnd;
                    fnOr:    ctrl.aluOp = aluOr;
                    fnSlt:   ctrl.aluOp = aluSlt;
                    default: ctrl = '0;
                endcase
            end
            opAddiu: {ctrl.regWrite, ctrl.aluSrc} = 2'b11;
            opLw:    {ctrl.regWrite, ctrl.memRead, ctrl.memToReg, ctrl.aluSrc} = 4'b1111;
            opSw:    {ctrl.memWrite, ctrl.aluSrc} = 2'b11;
            opBeq:
            begin
                ctrl.branch = 1'b1;
                ctrl.aluOp  = aluSub;
            end
            default: ctrl = '0;
        endcase
    end

    always_comb
    begin
        idEx.ctrl     = ctrl;
        idEx.pc       = pcQ;
        idEx.rsData   = readReg(rsAddr);
        idEx.rtData   = readReg(rtAddr);
        idEx.immData  = {{(dataWidth-16){instrQ[15]}}, instrQ[15:0]};
        idEx.rsAddr   = rsAddr;
        idEx.rtAddr   = rtAddr;
        idEx.destAddr = destAddr;
        RegData       = readReg(RegAddr);   // Debug port
    end

endmodule

// File: hw/executeStage.sv
// ----------------------------------------------------------
// Forwarding muxes, ALU and BEQ resolve
// Adds wrap, SLT is signed, target is pc+4 + (imm << 2)
// ----------------------------------------------------------
`timescale 1ns/1ps

module executeStage (
    input  cpuPkg::idExT                  idEx,
    input  cpuPkg::fwdSelT                fwdA,
    input  cpuPkg::fwdSelT                fwdB,
    input  logic [cpuPkg::dataWidth-1:0]  memResult,
    input  logic [cpuPkg::dataWidth-1:0]  wbResult,
    output cpuPkg::exMemT                 exMem,
    output logic                          branchTaken,
    output logic [cpuPkg::addrWidth-1:0]  branchTarget
);
    import cpuPkg::*;

    logic [dataWidth-1:0] opA;
    logic [dataWidth-1:0] opB;
    logic [dataWidth-1:0] aluB;
    logic [dataWidth-1:0] result;

    always_comb
    begin
        case (fwdA)
            fromMem: opA = memResult;
            fromWb:  opA = wbResult;
            default: opA = idEx.rsData;
        endcase
        case (fwdB)
            fromMem: opB = memResult;
            fromWb:  opB = wbResult;
            default: opB = idEx.rtData;
        endcase
    end

    assign aluB = idEx.ctrl.aluSrc ? idEx.immData : opB;

    // ALU ---------------------------------------------------
    always_comb
    begin
        case (idEx.ctrl.aluOp)
            aluSub:  result = opA - aluB;
            aluAnd:  result = opA & aluB;
            aluOr:   result = opA | aluB;
            aluSlt:  result = dataWidth'($signed(opA) < $signed(aluB));
            default: result = opA + aluB;
        endcase
    end

    assign exMem.ctrl      = idEx.ctrl;
    assign exMem.aluResult = result;
    assign exMem.storeData = opB;            // SW data, forwarded
    assign exMem.destAddr  = idEx.destAddr;

    assign branchTaken  = idEx.ctrl.branch && (opA == opB);
    assign branchTarget = idEx.pc + addrWidth'(4)
                        + {idEx.immData[addrWidth-3:0], 2'b00};

endmodule

// File: hw/hazardUnit.sv
// ----------------------------------------------------------
// Forward selects are picked in decode and registered for EX
// Stalls one cycle on load-use, squashes on taken branch
// ----------------------------------------------------------
`timescale 1ns/1ps

module hazardUnit (
    input  logic                            Clock,
    input  logic                            nReset,
    input  logic [cpuPkg::regAddrWidth-1:0] decRsAddr,
    input  logic [cpuPkg::regAddrWidth-1:0] decRtAddr,
    input  cpuPkg::ctrlT                    exCtrl,
    input  logic [cpuPkg::regAddrWidth-1:0] exDest,
    input  cpuPkg::ctrlT                    memCtrl,
    input  logic [cpuPkg::regAddrWidth-1:0] memDest,
    input  cpuPkg::ctrlT                    wbCtrl,
    input  logic [cpuPkg::regAddrWidth-1:0] wbDest,
    input  logic                            branchTaken,
    output cpuPkg::fwdSelT                  fwdA,
    output cpuPkg::fwdSelT                  fwdB,
    output logic                            nStall,
    output logic                            flush
);
    import cpuPkg::*;

    logic loadUse;

    // Producer now in EX sits in MEM next cycle, MEM moves to WB
    function automatic fwdSelT pickSource(input logic [regAddrWidth-1:0] src);
        if (src != '0 && exCtrl.regWrite && exDest == src)
            return fromMem;
        else if (src != '0 && memCtrl.regWrite && memDest == src)
            return fromWb;
        else
            return none;
    endfunction

    assign loadUse = exCtrl.memRead && exDest != '0
                   && (exDest == decRsAddr || exDest == decRtAddr);
    assign nStall  = !loadUse;
    assign flush   = branchTaken;

    always_ff @(posedge Clock or negedge nReset)
    begin
        if (!nReset)
        begin
            fwdA <= none;
            fwdB <= none;
        end
        else if (flush || loadUse)
        begin
            fwdA <= none;                    // Bubble enters EX
            fwdB <= none;
        end
        else
        begin
            fwdA <= pickSource(decRsAddr);
            fwdB <= pickSource(decRtAddr);
        end
    end

    assert property (@(posedge Clock) disable iff (!nReset) !nStall |=> nStall)
        else $error("hazardUnit: stall longer than one cycle");

    // Loads never forward from MEM, the stall pushes them to WB
    assert property (@(posedge Clock) disable iff (!nReset)
        (fwdA == fromMem || fwdB == fromMem) |-> memCtrl.regWrite && !memCtrl.memRead)
        else $error("hazardUnit: bad forward from memory stage");
    assert property (@(posedge Clock) disable iff (!nReset)
        (fwdA == fromWb || fwdB == fromWb) |-> wbCtrl.regWrite && wbDest != '0)
        else $error("hazardUnit: bad forward from writeback stage");

endmodule

// File: hw/processor.sv
// ----------------------------------------------------------
// Five stage core, memories external and read combinationally
// Load data is selected at the end of MEM and held in MEM/WB
// ----------------------------------------------------------
`timescale 1ns/1ps

module processor (
    input  logic                            Clock,
    input  logic                            nReset,
    output logic [cpuPkg::addrWidth-1:0]    InstrAddr,
    input  logic [cpuPkg::dataWidth-1:0]    InstrMem,
    output logic [cpuPkg::addrWidth-1:0]    MemAddr,
    output logic [cpuPkg::dataWidth-1:0]    WriteData,
    output logic                            MemRead,
    output logic                            MemWrite,
    input  logic [cpuPkg::dataWidth-1:0]    MemData,
    input  logic [cpuPkg::regAddrWidth-1:0] RegAddr,
    output logic [cpuPkg::dataWidth-1:0]    RegData,
    output logic                            nStall
);
    import cpuPkg::*;

    logic                    branchTaken;
    logic [addrWidth-1:0]    branchTarget;
    logic                    flush;
    logic [regAddrWidth-1:0] decRsAddr;
    logic [regAddrWidth-1:0] decRtAddr;
    idExT                    idExD, idExQ;
    exMemT                   exMemD, exMemQ;
    memWbT                   memWbD, memWbQ;
    fwdSelT                  fwdA, fwdB;
    logic [dataWidth-1:0]    wbResult;
    ctrlT                    wbCtrl;

    fetchStage fetch (
        .Clock(Clock), .nReset(nReset), .nStall(nStall), .branchTaken(branchTaken),
        .branchTarget(branchTarget), .InstrAddr(InstrAddr)
    );

    decodeStage decode (
        .Clock(Clock), .nReset(nReset), .InstrMem(InstrMem), .pcIn(InstrAddr),
        .nStall(nStall), .flush(flush), .wbRegWrite(memWbQ.regWrite),
        .wbAddr(memWbQ.destAddr), .wbData(wbResult), .RegAddr(RegAddr),
        .RegData(RegData), .rsAddr(decRsAddr), .rtAddr(decRtAddr), .idEx(idExD)
    );

    // Stall drops a bubble into EX
    pipeReg #(.Payload(idExT)) idExReg (
        .Clock(Clock), .nReset(nReset), .hold(1'b0), .flush(flush || !nStall),
        .d(idExD), .q(idExQ)
    );

    executeStage execute (
        .idEx(idExQ), .fwdA(fwdA), .fwdB(fwdB), .memResult(exMemQ.aluResult),
        .wbResult(wbResult), .exMem(exMemD), .branchTaken(branchTaken),
        .branchTarget(branchTarget)
    );

    pipeReg #(.Payload(exMemT)) exMemReg (
        .Clock(Clock), .nReset(nReset), .hold(1'b0), .flush(1'b0),
        .d(exMemD), .q(exMemQ)
    );

    // Memory stage ------------------------------------------
    assign MemAddr   = exMemQ.aluResult[addrWidth-1:0];
    assign WriteData = exMemQ.storeData;
    assign MemRead   = exMemQ.ctrl.memRead;
    assign MemWrite  = exMemQ.ctrl.memWrite;

    always_comb
    begin
        memWbD.regWrite  = exMemQ.ctrl.regWrite;
        memWbD.memToReg  = exMemQ.ctrl.memToReg;
        memWbD.aluResult = exMemQ.ctrl.memToReg ? MemData : exMemQ.aluResult;
        memWbD.destAddr  = exMemQ.destAddr;
    end

    pipeReg #(.Payload(memWbT)) memWbReg (
        .Clock(Clock), .nReset(nReset), .hold(1'b0), .flush(1'b0),
        .d(memWbD), .q(memWbQ)
    );

    assign wbResult = memWbQ.aluResult;       // Writeback value

    always_comb
    begin
        wbCtrl          = '0;
        wbCtrl.regWrite = memWbQ.regWrite;
        wbCtrl.memToReg = memWbQ.memToReg;
    end

    hazardUnit hazard (
        .Clock(Clock), .nReset(nReset), .decRsAddr(decRsAddr), .decRtAddr(decRtAddr),
        .exCtrl(idExQ.ctrl), .exDest(idExQ.destAddr),
        .memCtrl(exMemQ.ctrl), .memDest(exMemQ.destAddr),
        .wbCtrl(wbCtrl), .wbDest(memWbQ.destAddr), .branchTaken(branchTaken),
        .fwdA(fwdA), .fwdB(fwdB), .nStall(nStall), .flush(flush)
    );

endmodule

// File: verif/clockGen.sv
// ----------------------------------------------------------
// 4 ns clock, reset held low for the first 3 cycles
// ----------------------------------------------------------
`timescale 1ns/1ps

module clockGen (
    output logic Clock,
    output logic nReset
);

    initial
    begin
        Clock = 1'b0;
        forever #2 Clock = ~Clock;
    end

    initial
    begin
        nReset = 1'b0;
        repeat (3) @(posedge Clock);
        @(negedge Clock);
        nReset = 1'b1;              // Released away from the rising edge
    end

endmodule

// File: verif/processorTb.sv
// ----------------------------------------------------------
// Program, store list and final registers from the golden file
// Both memories are 64 words, indexed by address bits 7:2
// ----------------------------------------------------------
`timescale 1ns/1ps

module processorTb;
    import cpuPkg::*;

    localparam string goldenFile = "verif/golden_program.txt";
    localparam int    goldenWords = 96;
    localparam int    progBase    = 'h10;   // Golden image layout
    localparam int    storeBase   = 'h30;
    localparam int    regBase     = 'h40;
    localparam int    memWords    = 64;
    localparam logic [31:0] noReadData = 32'hBAD0_BAD0;   // Read bus without MemRead

    logic                    Clock;
    logic                    nReset;
    logic [addrWidth-1:0]    InstrAddr;
    logic [dataWidth-1:0]    InstrMem;
    logic [addrWidth-1:0]    MemAddr;
    logic [dataWidth-1:0]    WriteData;
    logic                    MemRead;
    logic                    MemWrite;
    logic [dataWidth-1:0]    MemData;
    logic [regAddrWidth-1:0] RegAddr;
    logic [dataWidth-1:0]    RegData;
    logic                    nStall;

    logic [dataWidth-1:0] golden [0:goldenWords-1];
    logic [dataWidth-1:0] instrMemory [0:memWords-1];
    logic [dataWidth-1:0] dataMemory [0:memWords-1] = '{default: '0};
    logic [addrWidth-1:0] loopAddr;
    logic                 programDone = 1'b0;
    logic                 stallSeen = 1'b0;
    int programLength;
    int storeCount;
    int cycleLimit;
    int cycleCount  = 0;
    int storeIndex  = 0;
    int storeErrors = 0;
    int regErrors   = 0;
    int otherErrors = 0;

    clockGen clocks (.Clock(Clock), .nReset(nReset));

    processor uut (
        .Clock(Clock), .nReset(nReset), .InstrAddr(InstrAddr), .InstrMem(InstrMem),
        .MemAddr(MemAddr), .WriteData(WriteData), .MemRead(MemRead), .MemWrite(MemWrite),
        .MemData(MemData), .RegAddr(RegAddr), .RegData(RegData), .nStall(nStall)
    );

    // Memory models ---------------------------------------------
    assign InstrMem = instrMemory[InstrAddr[7:2]];
    assign MemData  = MemRead ? dataMemory[MemAddr[7:2]] : noReadData;

    // Stores are checked in order and then written
    always @(negedge Clock)
    begin
        logic [addrWidth-1:0] expAddr;
        logic [dataWidth-1:0] expData;
        if (nReset && MemWrite)
        begin
            if (MemRead)
            begin
                storeErrors++;
                $display("** Error at %0d ns: MemRead high during the store to %h",
                         $time, MemAddr);
            end
            if (storeIndex >= storeCount)
            begin
                storeErrors++;
                $display("Unexpected extra store of %h to address %h at %0d ns",
                         WriteData, MemAddr, $time);
            end
            else
            begin
                expAddr = golden[storeBase + 2 * storeIndex][addrWidth-1:0];
                expData = golden[storeBase + 2 * storeIndex + 1];
                if (MemAddr != expAddr || WriteData != expData)
                begin
                    storeErrors++;
                    $display("** Error at %0d ns: store %0d wrote %h to %h, expected %h to %h",
                             $time, storeIndex, WriteData, MemAddr, expData, expAddr);
                end
                storeIndex++;
            end
            dataMemory[MemAddr[7:2]] = WriteData;
        end
    end

    always @(negedge Clock)
        if (nReset && !nStall)
            stallSeen <= 1'b1;

    always @(posedge Clock)
    begin
        if (nReset && !programDone)
        begin
            cycleCount++;
            if (cycleCount > cycleLimit)
            begin
                $display("Timeout: program did not reach its final loop in %0d cycles",
                         cycleLimit);
                $display("Verification failed");
                $finish;
            end
        end
    end

    // Debug port readback -----------------------------------
    task automatic checkRegisters();
        logic [dataWidth-1:0] expected;
        for (int r = 0; r < 32; r++)
        begin
            RegAddr = regAddrWidth'(r);
            @(negedge Clock);
            expected = golden[regBase + r];
            if (RegData !== expected)
            begin
                regErrors++;
                $display("** Error at %0d ns: register %0d reads %h, expected %h",
                         $time, r, RegData, expected);
            end
        end
    endtask

    initial
    begin
        RegAddr = '0;
        $readmemh(goldenFile, golden);
        programLength = int'(golden[0]);
        storeCount    = int'(golden[1]);
        cycleLimit    = programLength * 2 + 20;
        if (programLength < 1 || programLength > 32 || storeCount > 8)
        begin
            $display("Golden file header gives a program or store count out of range");
            $display("Verification failed");
            $finish;
        end
        else
        begin
            for (int i = 0; i < memWords; i++)
                instrMemory[i] = (i < programLength) ? golden[progBase + i] : '0;
            loopAddr = addrWidth'((programLength - 1) * 4);   // Final self-loop
            @(posedge nReset);
            while (InstrAddr != loopAddr)
                @(negedge Clock);
            repeat (4) @(negedge Clock);    // Last older instruction written by now
            programDone = 1'b1;
            checkRegisters();
            if (storeIndex != storeCount)
            begin
                otherErrors++;
                $display("Only %0d of %0d expected stores were seen", storeIndex, storeCount);
            end
            if (!stallSeen)
            begin
                otherErrors++;
                $display("nStall never went low, so no load-use stall happened");
            end
            $display("Errors: %0d store, %0d register, %0d other",
                     storeErrors, regErrors, otherErrors);
            if (storeErrors + regErrors + otherErrors == 0)
                $display("Verification passed");
            else
                $display("Verification failed");
            $finish;
        end
    end

endmodule

// File: verif/golden_program.txt
// @00 program length, store count | @10 program words
// @30 store address and data pairs | @40 final values of r0 to r31
@00
0000001C 00000004
@10
2401000C 2402000A 00221821 00612023 // addiu r1  addiu r2  addu r3  subu r4
00832824 00A13025 0083382A 2408FFFF // and r5  or r6  slt r7  addiu r8 = -1
0101482A 00015023 240B0040 AD630000 // signed slt r9  subu r10 wraps  addiu r11  sw r3
AD660004 8D6C0000 01816821 AD6D0008 // sw r6  lw r12  addu r13 load-use  sw r13
8D6E0004 AD6E000C 10220002 240F0007 // lw r14  sw r14 load-use  beq not taken  addiu r15
2413000A 12620002 24100001 24110001 // addiu r19  beq taken  two skipped words
24120009 24000005 0001A021 1000FFFF // branch target  write r0  addu r20  self-loop
@30
00000040 00000016
00000044 0000000E
00000048 00000022
0000004C 0000000E
@40
00000000 0000000C 0000000A 00000016 0000000A 00000002 0000000E 00000001
FFFFFFFF 00000001 FFFFFFF4 00000040 00000016 00000022 0000000E 00000007
00000000 00000000 00000009 0000000A 0000000C 00000000 00000000 00000000
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000

// File: flist.f
hw/cpuPkg.sv
hw/pipeReg.sv
hw/fetchStage.sv
hw/decodeStage.sv
hw/executeStage.sv
hw/hazardUnit.sv
hw/processor.sv
verif/clockGen.sv
verif/processorTb.sv

// File: Makefile
TOP = processorTb

.PHONY: all lint clean

all:
	verilator --binary --timing --assert -f flist.f --top-module $(TOP)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -x "Verification passed" > /dev/null

lint:
	verilator --lint-only --timing -f flist.f --top-module $(TOP)

clean:
	rm -rf obj_dir
